//--- rtl/neoPkg.sv
package neoPkg;

  // buffer geometry, 12 bytes = 12 packed pixels or 3 pixels of 4 bytes
  localparam int BUFFER_END  = 11;                    // index of last buffer byte
  localparam int BUFFER_BITS = $clog2(BUFFER_END + 1); // address width of the buffer

  // bit timing
  localparam int CYCLES_PER_SLOT = 2;  // clocks per pattern slot
  localparam int SLOT_CNT_BITS   = (CYCLES_PER_SLOT > 1) ? $clog2(CYCLES_PER_SLOT) : 1;
  localparam int RESET_SLOTS     = 16; // latch time in slots, line held low

  // slot patterns, bit n is slot n, slot 0 goes out first
  localparam logic [7:0] PATTERN_ONE  = 8'b0001_1111; // high for slots 0..4
  localparam logic [7:0] PATTERN_ZERO = 8'b0000_0011; // high for slots 0..1

  // write port commands
  typedef enum logic [1:0] {
    opWritePixel,   // wrData -> buffer[wrAddr]
    opWriteCtrl,    // wrData[0] run, wrData[1] mode32
    opStart         // request one frame
  } busOpT;

  typedef enum logic [1:0] {
    stIdle,
    stTransmit,
    stLatch
  } seqStateT;

  typedef struct packed {
    logic run;      // clearing it aborts a frame
    logic mode32;   // 1: 4 bytes per pixel, 0: one packed byte per pixel
  } ctrlRegT;

  // where the sequencer is in the frame
  typedef struct packed {
    logic                   transmit;
    logic [BUFFER_BITS-1:0] pixelIndex;
    logic [1:0]             channelIndex; // 0 green, 1 blue, 2 red
    logic [2:0]             bitIndex;     // 7 down to 0
    logic [2:0]             slotIndex;    // 0 up to 7
  } streamPosT;

endpackage

//--- rtl/neoRegDecode.sv
`timescale 1ns/1ps

module neoRegDecode (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic                             wrEn,
  input  neoPkg::busOpT                    wrOp,
  input  logic [neoPkg::BUFFER_BITS-1:0]   wrAddr,
  input  logic [7:0]                       wrData,
  output neoPkg::ctrlRegT                  ctrl,
  output logic                             startPulse,
  output logic [7:0]                       pixels [neoPkg::BUFFER_END+1]
);

  logic addrInRange;   // wrAddr points inside the buffer
  logic pixelWrite;
  logic ctrlWrite;
  logic startWrite;

  // addresses past BUFFER_END fall off silently
  assign addrInRange = int'(wrAddr) <= neoPkg::BUFFER_END;

  // one-hot command decode
  always_comb begin
    pixelWrite = 1'b0;
    ctrlWrite  = 1'b0;
    startWrite = 1'b0;
    if (wrEn) begin
      case (wrOp)
        neoPkg::opWritePixel: pixelWrite = addrInRange;
        neoPkg::opWriteCtrl:  ctrlWrite  = 1'b1;
        neoPkg::opStart:      startWrite = 1'b1;
        default: ;            // unused encoding, nothing happens
      endcase
    end
  end

  // pixel buffer, cleared on reset so an unwritten strip stays dark
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i <= neoPkg::BUFFER_END; i++) begin
        pixels[i] <= 8'h00;
      end
    end else if (pixelWrite) begin
      pixels[wrAddr] <= wrData;
    end
  end

  // control register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrl <= '0;
    end else if (ctrlWrite) begin
      ctrl.run    <= wrData[0];
      ctrl.mode32 <= wrData[1];
    end
  end

  // start is only a request here, the sequencer decides whether to take it
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      startPulse <= 1'b0;
    end else begin
      startPulse <= startWrite; // single cycle, one per opStart
    end
  end

endmodule

//--- rtl/neoSequencer.sv
`timescale 1ns/1ps

module neoSequencer (
  input  logic              clk,
  input  logic              arstN,
  input  neoPkg::ctrlRegT   ctrl,
  input  logic              startPulse,
  output neoPkg::streamPosT pos,
  output logic              busy,
  output logic              frameDone
);

  neoPkg::seqStateT                     state;
  logic [neoPkg::SLOT_CNT_BITS-1:0]     cycleCnt;   // clocks within a slot
  logic [2:0]                           slotIdx;
  logic [2:0]                           bitIdx;     // msb first
  logic [1:0]                           chanIdx;
  logic [neoPkg::BUFFER_BITS-1:0]       pixelIdx;
  logic [$clog2(neoPkg::RESET_SLOTS)-1:0] latchCnt; // latch slots elapsed
  logic                                 mode32Q;    // mode frozen at frame start

  logic slotDone;
  logic bitDone;
  logic pixelDone;
  logic lastPixel;
  logic latchDone;

  assign slotDone  = int'(cycleCnt) == neoPkg::CYCLES_PER_SLOT - 1;
  assign bitDone   = slotDone && (slotIdx == 3'd7);
  assign pixelDone = bitDone && (bitIdx == 3'd0) && (chanIdx == 2'd2);
  // 3 pixels of 4 bytes, or one pixel per byte
  assign lastPixel = mode32Q ? (int'(pixelIdx) == (neoPkg::BUFFER_END + 1) / 4 - 1)
                             : (int'(pixelIdx) == neoPkg::BUFFER_END);
  assign latchDone = slotDone && (int'(latchCnt) == neoPkg::RESET_SLOTS - 1);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= neoPkg::stIdle;
      cycleCnt <= '0;
      slotIdx  <= 3'd0;
      bitIdx   <= 3'd7;
      chanIdx  <= 2'd0;
      pixelIdx <= '0;
      latchCnt <= '0;
      mode32Q  <= 1'b0;
    end else begin
      case (state)
        neoPkg::stIdle: begin
          // park counters at the first slot of the frame
          cycleCnt <= '0;
          slotIdx  <= 3'd0;
          bitIdx   <= 3'd7;
          chanIdx  <= 2'd0;
          pixelIdx <= '0;
          latchCnt <= '0;
          if (startPulse && ctrl.run) begin
            state   <= neoPkg::stTransmit;
            mode32Q <= ctrl.mode32;
          end
        end
        neoPkg::stTransmit: begin
          if (!ctrl.run) begin
            state <= neoPkg::stIdle;      // abort, no done pulse
          end else begin
            cycleCnt <= slotDone ? '0 : cycleCnt + 1'b1;
            if (slotDone) slotIdx <= slotIdx + 3'd1; // wraps 7 -> 0
            if (bitDone) begin
              bitIdx <= bitIdx - 3'd1;    // wraps 0 -> 7 for next channel
              if (bitIdx == 3'd0) begin
                chanIdx <= (chanIdx == 2'd2) ? 2'd0 : chanIdx + 2'd1;
              end
            end
            if (pixelDone) begin
              if (lastPixel) state <= neoPkg::stLatch;
              else           pixelIdx <= pixelIdx + 1'b1;
            end
          end
        end
        neoPkg::stLatch: begin
          cycleCnt <= slotDone ? '0 : cycleCnt + 1'b1;
          if (slotDone) latchCnt <= latchCnt + 1'b1;
          if (!ctrl.run || latchDone) state <= neoPkg::stIdle;
        end
        default: state <= neoPkg::stIdle;
      endcase
    end
  end

  assign pos = '{
    transmit:     (state == neoPkg::stTransmit),
    pixelIndex:   pixelIdx,
    channelIndex: chanIdx,
    bitIndex:     bitIdx,
    slotIndex:    slotIdx
  };

  assign busy      = (state != neoPkg::stIdle);
  // last latch clock, suppressed when the frame is being aborted
  assign frameDone = (state == neoPkg::stLatch) && latchDone && ctrl.run;

endmodule

//--- rtl/neoStreamEncoder.sv
`timescale 1ns/1ps

module neoStreamEncoder (
  input  logic              clk,
  input  logic              arstN,
  input  neoPkg::ctrlRegT   ctrl,
  input  neoPkg::streamPosT pos,
  input  logic [7:0]        pixels [neoPkg::BUFFER_END+1],
  output logic              neoData
);

  logic [neoPkg::BUFFER_BITS-1:0] wideAddr;   // byte of a 4-byte pixel
  logic [7:0]                     wideByte;   // 32-bit mode channel
  logic [7:0]                     packedByte; // 8-bit mode source pixel
  logic [7:0]                     chanByte;   // channel value being sent
  logic [7:0]                     pattern;
  logic                           slotLevel;

  // 4*pixel + channel, byte 3 of each pixel is never addressed
  assign wideAddr   = {pos.pixelIndex[neoPkg::BUFFER_BITS-3:0], pos.channelIndex};
  assign wideByte   = pixels[wideAddr];
  assign packedByte = pixels[pos.pixelIndex];

  always_comb begin
    if (ctrl.mode32) begin
      chanByte = wideByte;
    end else begin
      // packed source: [7:6] blue, [5:3] green, [2:0] red
      // each field lands in the top bits of its channel
      case (pos.channelIndex)
        2'd0:    chanByte = {packedByte[5:3], 5'b0_0000}; // green
        2'd1:    chanByte = {packedByte[7:6], 6'b00_0000}; // blue
        2'd2:    chanByte = {packedByte[2:0], 5'b0_0000}; // red
        default: chanByte = 8'h00;
      endcase
    end
  end

  // one bit of the channel picks the slot pattern
  assign pattern   = chanByte[pos.bitIndex] ? neoPkg::PATTERN_ONE : neoPkg::PATTERN_ZERO;
  assign slotLevel = pattern[pos.slotIndex];

  // registered pin, low outside transmit and as soon as run drops
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      neoData <= 1'b0;
    end else begin
      neoData <= pos.transmit && ctrl.run && slotLevel;
    end
  end

endmodule

//--- rtl/neoTop.sv
`timescale 1ns/1ps

module neoTop (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           wrEn,
  input  neoPkg::busOpT                  wrOp,
  input  logic [neoPkg::BUFFER_BITS-1:0] wrAddr,
  input  logic [7:0]                     wrData,
  output logic                           neoData,
  output logic                           busy,
  output logic                           frameDone
);

  neoPkg::ctrlRegT   ctrl;        // run and mode, shared by sequencer and encoder
  logic              startPulse;
  logic [7:0]        pixels [neoPkg::BUFFER_END+1];
  neoPkg::streamPosT pos;         // frame position, sequencer -> encoder

  neoRegDecode decode_i (
    .clk        (clk),
    .arstN      (arstN),
    .wrEn       (wrEn),
    .wrOp       (wrOp),
    .wrAddr     (wrAddr),
    .wrData     (wrData),
    .ctrl       (ctrl),
    .startPulse (startPulse),
    .pixels     (pixels)
  );

  neoSequencer execute_i (
    .clk        (clk),
    .arstN      (arstN),
    .ctrl       (ctrl),
    .startPulse (startPulse),
    .pos        (pos),
    .busy       (busy),
    .frameDone  (frameDone)
  );

  neoStreamEncoder result_i (
    .clk     (clk),
    .arstN   (arstN),
    .ctrl    (ctrl),
    .pos     (pos),
    .pixels  (pixels),
    .neoData (neoData)      // one clock behind pos
  );

endmodule

//--- test/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

endmodule

//--- test/neoTop_props.sv
`timescale 1ns/1ps

module neoTopProps (
  input logic clk,
  input logic arstN,
  input logic neoData,
  input logic busy,
  input logic frameDone
);

  int violations = 0; // failed property count

  // done is a single-cycle pulse
  donePulseSingle: assert property (@(posedge clk) disable iff (!arstN)
    frameDone |=> !frameDone)
    else begin
      $error("frameDone stayed high for two cycles");
      violations++;
    end

  // line is dark while no frame runs
  dataQuietWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
    !busy |-> !neoData)
    else begin
      $error("neoData high while busy is low");
      violations++;
    end

  busyDropsAfterDone: assert property (@(posedge clk) disable iff (!arstN)
    frameDone |=> !busy)
    else begin
      $error("busy still high the cycle after frameDone");
      violations++;
    end

endmodule

//--- test/neoTb.sv
`timescale 1ns/1ps

module neoTb;

  logic                           clk;
  logic                           arstN;
  logic                           wrEn;
  neoPkg::busOpT                  wrOp;
  logic [neoPkg::BUFFER_BITS-1:0] wrAddr;
  logic [7:0]                     wrData;
  logic                           neoData;
  logic                           busy;
  logic                           frameDone;

  integer     seed;
  logic [7:0] model [neoPkg::BUFFER_END+1]; // mirror of the pixel buffer
  bit         expBits[$];
  bit         gotBits[$];                   // decoded by the monitor and never cleared
  int         highRun = 0;
  int         lowRun = 0;
  int         lowAtDone = 0;                // low cycles seen when done pulsed
  int         doneCount = 0;
  int         badWidths = 0;
  int         busyAfterDone = 0;
  bit         donePrev = 1'b0;
  int         bitBase;                      // monitor counts at frame start
  int         doneBase;
  int         badBase;
  int         busyBase;
  int         testErrors = 0;
  int         totalErrors = 0;
  int         failedTests = 0;
  int         testsRun = 0;

  tbClock clock_i (.clk(clk));

  neoTop dut_i (
    .clk       (clk),
    .arstN     (arstN),
    .wrEn      (wrEn),
    .wrOp      (wrOp),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .neoData   (neoData),
    .busy      (busy),
    .frameDone (frameDone)
  );

  bind neoTop neoTopProps props_i (
    .clk       (clk),
    .arstN     (arstN),
    .neoData   (neoData),
    .busy      (busy),
    .frameDone (frameDone)
  );

  // pulse width monitor sampling on the falling edge
  always @(negedge clk) begin
    if (arstN) begin
      if (neoData) begin
        highRun++;
        lowRun = 0;
      end else begin
        if (highRun == 5 * neoPkg::CYCLES_PER_SLOT) gotBits.push_back(1'b1);
        else if (highRun == 2 * neoPkg::CYCLES_PER_SLOT) gotBits.push_back(1'b0);
        else if (highRun != 0) badWidths++; // neither a one nor a zero
        highRun = 0;
        lowRun++;
      end
      if (donePrev && busy) busyAfterDone++;
      if (frameDone) begin
        doneCount++;
        lowAtDone = lowRun; // includes the done cycle itself
      end
      donePrev = frameDone;
    end
  end

  task automatic logError(input string msg);
    $display("%s", msg);
    testErrors++;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    totalErrors += testErrors;
    if (testErrors != 0) failedTests++;
    $display("test %0d %s: %s, %0d errors", testsRun, name,
             (testErrors == 0) ? "ok" : "FAILED", testErrors);
    testErrors = 0;
  endtask

  // one command per call on the falling edge
  task automatic sendCmd(input neoPkg::busOpT op, input int addr, input logic [7:0] data);
    @(negedge clk);
    wrEn   = 1'b1;
    wrOp   = op;
    wrAddr = addr[neoPkg::BUFFER_BITS-1:0];
    wrData = data;
    @(negedge clk);
    wrEn   = 1'b0;
  endtask

  task automatic waitBusy(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (busy !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (busy === level)
      else logError($sformatf("timed out waiting for busy to be %0d at %s", level, what));
  endtask

  task automatic fillBuffer();
    for (int i = 0; i <= neoPkg::BUFFER_END; i++) begin
      model[i] = 8'($random(seed));
      sendCmd(neoPkg::opWritePixel, i, model[i]);
    end
  endtask

  // green then blue then red per pixel with msb first
  task automatic buildExpected(input bit mode32);
    logic [7:0] chan [3];
    int         pixCount;
    pixCount = mode32 ? (neoPkg::BUFFER_END + 1) / 4 : neoPkg::BUFFER_END + 1;
    expBits.delete();
    for (int p = 0; p < pixCount; p++) begin
      if (mode32) begin
        for (int c = 0; c < 3; c++) chan[c] = model[4 * p + c]; // byte 3 skipped
      end else begin
        // packed fields moved to the top of each channel
        chan[0] = 8'(model[p][5:3]) << 5; // green
        chan[1] = 8'(model[p][7:6]) << 6; // blue
        chan[2] = 8'(model[p][2:0]) << 5; // red
      end
      for (int c = 0; c < 3; c++) begin
        for (int b = 7; b >= 0; b--) expBits.push_back(chan[c][b]);
      end
    end
  endtask

  task automatic startFrame(input bit mode32);
    bitBase  = gotBits.size();
    doneBase = doneCount;
    badBase  = badWidths;
    busyBase = busyAfterDone;
    sendCmd(neoPkg::opWriteCtrl, 0, {6'd0, mode32, 1'b1}); // run set
    sendCmd(neoPkg::opStart, 0, 8'h00);
    waitBusy(1'b1, 10, "frame start");
  endtask

  task automatic compareBits();
    int got;
    got = gotBits.size() - bitBase;
    assert (got == expBits.size())
      else logError($sformatf("[ERROR] neoData bit count: expected 0x%0h got 0x%0h",
                              expBits.size(), got));
    for (int i = 0; i < expBits.size() && i < got; i++) begin
      assert (gotBits[bitBase + i] == expBits[i])
        else logError($sformatf("[ERROR] neoData bit %0d: expected 0x%0h got 0x%0h",
                                i, expBits[i], gotBits[bitBase + i]));
    end
    assert (badWidths == badBase)
      else logError("neoData had a high pulse that is neither a one nor a zero");
    assert (doneCount - doneBase == 1)
      else logError($sformatf("[ERROR] frameDone pulses: expected 0x1 got 0x%0h",
                              doneCount - doneBase));
  endtask

  initial begin
    int n;
    seed   = 32'h7fefe246;
    arstN  = 1'b0;
    wrEn   = 1'b0;
    wrOp   = neoPkg::opWritePixel;
    wrAddr = '0;
    wrData = 8'h00;
    repeat (3) @(posedge clk); // reset held for 3 cycles
    @(negedge clk);
    arstN = 1'b1;

    for (int i = 0; i < 20; i++) begin
      assert ({neoData, busy, frameDone} == 3'b000)
        else logError($sformatf("[ERROR] {neoData,busy,frameDone}: expected 0x0 got 0x%0h",
                                {neoData, busy, frameDone}));
      @(negedge clk);
    end
    endTest("idle after reset");

    fillBuffer();
    buildExpected(1'b0);
    startFrame(1'b0);
    waitBusy(1'b0, 6000, "8-bit frame end");
    compareBits();
    endTest("8-bit frame");

    fillBuffer();
    buildExpected(1'b1);
    startFrame(1'b1);
    waitBusy(1'b0, 2000, "32-bit frame end");
    compareBits();
    endTest("32-bit frame");

    // latch figures come from the 32-bit frame just sent
    assert (lowAtDone >= neoPkg::RESET_SLOTS * neoPkg::CYCLES_PER_SLOT)
      else logError($sformatf("[ERROR] neoData latch low: expected >= 0x%0h got 0x%0h",
                              neoPkg::RESET_SLOTS * neoPkg::CYCLES_PER_SLOT, lowAtDone));
    assert (busyAfterDone == busyBase) else logError("busy did not fall right after frameDone");
    endTest("latch and done");

    sendCmd(neoPkg::opWriteCtrl, 0, 8'h00); // run clear
    sendCmd(neoPkg::opStart, 0, 8'h00);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (!busy) else logError("a start was accepted with run clear");
    end
    buildExpected(1'b0);
    startFrame(1'b0);
    sendCmd(neoPkg::opStart, 0, 8'h00); // second start while busy
    waitBusy(1'b0, 6000, "frame end after repeated start");
    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      assert (!busy) else logError("a start given while busy began an extra frame");
    end
    compareBits();
    endTest("ignored starts");

    startFrame(1'b1);
    repeat (400) @(negedge clk);            // well inside the 32-bit frame
    sendCmd(neoPkg::opWriteCtrl, 0, 8'h02); // run clear with mode kept
    n = 0;
    while ((busy || neoData) && n < 3) begin
      @(negedge clk);
      n++;
    end
    assert (!busy && !neoData) else logError("abort did not stop the frame within 3 cycles");
    repeat (40) @(negedge clk);             // longer than a latch
    assert (doneCount == doneBase) else logError("frameDone pulsed after an abort");
    buildExpected(1'b1);
    startFrame(1'b1);
    waitBusy(1'b0, 2000, "frame end after abort");
    compareBits();
    endTest("abort and restart");

    $display("tests %0d, failed %0d, errors %0d, property failures %0d",
             testsRun, failedTests, totalErrors, dut_i.props_i.violations);
    if (failedTests == 0 && dut_i.props_i.violations == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- all.f
rtl/neoPkg.sv
rtl/neoRegDecode.sv
rtl/neoSequencer.sv
rtl/neoStreamEncoder.sv
rtl/neoTop.sv
test/tbClock.sv
test/neoTop_props.sv
test/neoTb.sv

//--- run.sh
#!/bin/sh
# builds the neoTop testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module neoTb -f all.f
# error limit lets the testbench reach its own summary after a property failure
./obj_dir/VneoTb +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "Simulation passed"
